// ==== source/knight_pkg.sv ====
// Knight command processor shared definitions.
// Widths, opcodes, command field positions, sequencer state codes
// and the default tuning constants.
`default_nettype none

package knight_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int cmd_w = 16;  // Command word from the BLE link.
  localparam int hdg_w = 12;  // Heading and heading error.
  localparam int spd_w = 10;  // Forward speed.
  localparam int sq_w  = 4;   // Square count of a move.

  ////////////////////////////////////////
  // Opcodes in cmd[15:12]
  ////////////////////////////////////////
  localparam logic [3:0] op_cal     = 4'h2;  // Gyro calibration.
  localparam logic [3:0] op_mov     = 4'h4;  // Plain move.
  localparam logic [3:0] op_fanfare = 4'h5;  // Move with fanfare.
  localparam logic [3:0] op_tour    = 4'h6;  // Hand over to the tour logic.

  // Command field positions.
  localparam int hdg_field_lsb = 4;   // Heading field low bit.
  localparam int hdg_field_msb = 11;  // Heading field high bit.
  localparam int sq_field_msb  = 3;   // Square field occupies cmd[3:0].

  ////////////////////////////////////////
  // Sequencer state codes
  ////////////////////////////////////////
  localparam logic [2:0] st_idle = 3'd0;  // Waiting for a command.
  localparam logic [2:0] st_cal  = 3'd1;  // Gyro calibration running.
  localparam logic [2:0] st_move = 3'd2;  // Turning to the new heading.
  localparam logic [2:0] st_incr = 3'd3;  // Ramping up, counting lines.
  localparam logic [2:0] st_decr = 3'd4;  // Ramping down to a stop.

  ////////////////////////////////////////
  // Default tuning
  ////////////////////////////////////////
  localparam logic [spd_w-1:0] ramp_up_default   = 10'h020;  // Speed step up.
  localparam logic [spd_w-1:0] ramp_down_default = 10'h040;  // Speed step down.
  localparam logic [hdg_w-1:0] nudge_default     = 12'h1FF;  // IR nudge size.
  localparam logic [hdg_w-1:0] align_tol         = 12'h02C;  // Aligned below this.

endpackage

`default_nettype wire

// ==== source/cmd_reg.sv ====
// Command register.
// Holds the square count and the desired heading of the command
// most recently accepted by the sequencer.
`default_nettype none

module cmd_reg
  import knight_pkg::*;
(
  input  wire logic                    clk,              // System clock.
  input  wire logic                    rst_n,            // Async reset, active low.
  input  wire logic [cmd_w-1:0]        cmd,              // Live command word.
  input  wire logic                    accept,           // Command consumed this cycle.
  output logic      [sq_w-1:0]         squares,          // Squares to travel.
  output logic signed [hdg_w-1:0]      desired_heading   // Target heading.
);

  localparam int hfield_w = hdg_field_msb - hdg_field_lsb + 1;  // 8 bits.

  logic [hfield_w-1:0] hdg_field;   // Raw heading field of the command.
  logic [hdg_w-1:0]    hdg_next;    // Expanded heading to load.

  assign hdg_field = cmd[hdg_field_msb:hdg_field_lsb];

  // A zero field means due north, anything else gets 0xF below it
  // so the target sits in the middle of its step.
  assign hdg_next = (hdg_field == '0) ? '0 : {hdg_field, 4'hF};

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      squares <= '0;                       // Nothing to travel yet.
    end else if (accept) begin
      squares <= cmd[sq_field_msb:0];      // Square field of the command.
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      desired_heading <= '0;               // Face north after reset.
    end else if (accept) begin
      desired_heading <= hdg_next;         // Held until the next command.
    end
  end

endmodule

`default_nettype wire

// ==== source/heading_err.sv ====
// Heading error for the PID.
// Actual minus desired heading with a nudge from the side IR sensors,
// plus a flag that says the robot points close enough to move.
`default_nettype none

module heading_err
  import knight_pkg::*;
#(
  parameter logic [hdg_w-1:0] nudge = nudge_default  // Nudge magnitude.
) (
  input  wire logic signed [hdg_w-1:0] heading,          // Gyro heading.
  input  wire logic signed [hdg_w-1:0] desired_heading,  // Target heading.
  input  wire logic                    lft_ir,           // Drifted onto left line.
  input  wire logic                    rght_ir,          // Drifted onto right line.
  output logic signed [hdg_w-1:0]      error,            // Error word to the PID.
  output logic                         aligned           // Close enough to drive.
);

  localparam logic [hdg_w-1:0] nudge_neg = -nudge;  // Two's complement of nudge.

  logic [hdg_w-1:0] nudge_term;  // Selected nudge offset.
  logic [hdg_w-1:0] err_abs;     // Magnitude of the error.

  // Left sensor wins when both see a line.
  always_comb begin
    if (lft_ir) begin
      nudge_term = nudge;       // Steer back to the right.
    end else if (rght_ir) begin
      nudge_term = nudge_neg;   // Steer back to the left.
    end else begin
      nudge_term = '0;
    end
  end

  // Wraps modulo 12 bits, as the heading does.
  assign error = heading - desired_heading + $signed(nudge_term);

  assign err_abs = error[hdg_w-1] ? -error : error;  // Fold negative errors.
  assign aligned = (err_abs < align_tol);             // Inside the window.

endmodule

`default_nettype wire

// ==== source/square_counter.sv ====
// Square counter.
// Counts rising edges of the centre IR sensor during a move and flags
// the end once two lines per square have passed.
`default_nettype none

module square_counter
  import knight_pkg::*;
(
  input  wire logic            clk,        // System clock.
  input  wire logic            rst_n,      // Async reset, active low.
  input  wire logic            cntr_ir,    // Centre IR, high over a line.
  input  wire logic            launch,     // Start of a new move.
  input  wire logic [sq_w-1:0] squares,    // Squares to travel.
  output logic                 move_done   // All crossings seen.
);

  logic            cntr_ir_q;   // Previous centre IR sample.
  logic            ir_rise;     // Rising edge of the centre IR.
  logic [sq_w:0]   cross_cnt;   // Line crossings since launch.

  ////////////////////////////////////////
  // Edge detect
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cntr_ir_q <= 1'b0;
    end else begin
      cntr_ir_q <= cntr_ir;   // One cycle of history.
    end
  end

  assign ir_rise = cntr_ir & ~cntr_ir_q;

  ////////////////////////////////////////
  // Crossing count
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cross_cnt <= '0;
    end else if (launch) begin
      cross_cnt <= '0;                  // Fresh move.
    end else if (ir_rise) begin
      cross_cnt <= cross_cnt + 1'b1;    // Each square has two lines.
    end
  end

  // Twice squares always fits, 2 x 15 is 30.
  assign move_done = (cross_cnt == {squares, 1'b0});

endmodule

`default_nettype wire

// ==== source/speed_ramp.sv ====
// Forward speed ramp.
// Steps the forward speed up or down once per gyro heading update,
// capping at the top two bits set and stopping at zero.
`default_nettype none

module speed_ramp
  import knight_pkg::*;
#(
  parameter logic [spd_w-1:0] ramp_up   = ramp_up_default,   // Step up per update.
  parameter logic [spd_w-1:0] ramp_down = ramp_down_default  // Step down per update.
) (
  input  wire logic         clk,            // System clock.
  input  wire logic         rst_n,          // Async reset, active low.
  input  wire logic         launch,         // Clears the speed.
  input  wire logic         ramp_up_en,     // Accelerate phase.
  input  wire logic         ramp_down_en,   // Brake phase.
  input  wire logic         heading_rdy,    // New gyro reading.
  output logic [spd_w-1:0]  frwrd,          // Forward speed to the motors.
  output logic              at_zero         // Robot has stopped.
);

  logic max_spd;    // Top two bits both set.
  logic last_step;  // Next step down reaches or passes zero.

  assign max_spd   = &frwrd[spd_w-1 -: 2];
  assign last_step = (frwrd <= ramp_down);
  assign at_zero   = (frwrd == '0);

  ////////////////////////////////////////
  // Speed register
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (launch) begin
      frwrd <= '0;                          // Every move starts from rest.
    end else if (heading_rdy) begin
      if (ramp_up_en) begin
        if (!max_spd) begin
          frwrd <= frwrd + ramp_up;         // Still below cruise speed.
        end
      end else if (ramp_down_en) begin
        if (last_step) begin
          frwrd <= '0;                      // Clamp, no wrap below zero.
        end else begin
          frwrd <= frwrd - ramp_down;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/cmd_fsm.sv ====
// Command sequencer.
// Dispatches commands from idle, runs calibration, and walks a move
// through turn, ramp up with line counting, and ramp down.
`default_nettype none

module cmd_fsm
  import knight_pkg::*;
(
  input  wire logic       clk,           // System clock.
  input  wire logic       rst_n,         // Async reset, active low.
  input  wire logic       cmd_rdy,       // Command waiting.
  input  wire logic [3:0] cmd_op,        // Live opcode field.
  input  wire logic       cal_done,      // Gyro calibration finished.
  input  wire logic       aligned,       // Heading error inside window.
  input  wire logic       move_done,     // All crossings counted.
  input  wire logic       at_zero,       // Speed back at zero.
  output logic            clr_cmd_rdy,   // Command consumed.
  output logic            strt_cal,      // Kick off gyro calibration.
  output logic            send_resp,     // Command complete.
  output logic            tour_go,       // Start the tour logic.
  output logic            fanfare_go,    // Play the fanfare.
  output logic            moving,        // Robot is driving.
  output logic            launch,        // Start of the forward run.
  output logic            ramp_up_en,    // Accelerate on heading updates.
  output logic            ramp_down_en   // Brake on heading updates.
);

  logic [2:0] state;       // Current state.
  logic [2:0] nxt_state;   // Next state.
  logic       fanfare_mv;  // Current move is a fanfare move.

  ////////////////////////////////////////
  // State and fanfare flag
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= nxt_state;
    end
  end

  // Captured at accept, since cmd may change once it is consumed.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fanfare_mv <= 1'b0;
    end else if (clr_cmd_rdy) begin
      fanfare_mv <= (cmd_op == op_fanfare);
    end
  end

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////
  always_comb begin
    nxt_state    = state;   // Hold by default.
    clr_cmd_rdy  = 1'b0;
    strt_cal     = 1'b0;
    send_resp    = 1'b0;
    tour_go      = 1'b0;
    fanfare_go   = 1'b0;
    moving       = 1'b0;
    launch       = 1'b0;
    ramp_up_en   = 1'b0;
    ramp_down_en = 1'b0;

    case (state)
      st_idle: begin
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;             // Every opcode is consumed.
          case (cmd_op)
            op_tour: begin
              tour_go = 1'b1;             // Tour logic takes over, stay idle.
            end
            op_cal: begin
              strt_cal  = 1'b1;
              nxt_state = st_cal;
            end
            op_mov, op_fanfare: begin
              nxt_state = st_move;        // Turn to the new heading first.
            end
            default: begin
              nxt_state = st_idle;        // Unknown opcode, dropped.
            end
          endcase
        end
      end

      st_cal: begin
        if (cal_done) begin
          send_resp = 1'b1;               // Answer in the cal_done cycle.
          nxt_state = st_idle;
        end
      end

      st_move: begin
        if (aligned) begin
          moving    = 1'b1;
          launch    = 1'b1;               // Clears speed and crossings.
          nxt_state = st_incr;
        end
      end

      st_incr: begin
        moving     = 1'b1;
        ramp_up_en = 1'b1;
        if (move_done) begin
          fanfare_go = fanfare_mv;        // Only for a fanfare move.
          nxt_state  = st_decr;
        end
      end

      st_decr: begin
        ramp_down_en = 1'b1;
        if (at_zero) begin
          send_resp = 1'b1;               // Stopped, move complete.
          nxt_state = st_idle;
        end else begin
          moving = 1'b1;                  // Still rolling.
        end
      end

      default: begin
        nxt_state = st_idle;              // Recover from unused codes.
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/cmd_proc.sv ====
// Knight command processor top level.
// Connects the command register, heading error, square counter,
// speed ramp and sequencer, and hands the tuning parameters down.
`default_nettype none

module cmd_proc
  import knight_pkg::*;
#(
  parameter logic [spd_w-1:0] ramp_up   = ramp_up_default,    // Speed step up.
  parameter logic [spd_w-1:0] ramp_down = ramp_down_default,  // Speed step down.
  parameter logic [hdg_w-1:0] nudge     = nudge_default       // IR nudge size.
) (
  input  wire logic                    clk,          // System clock.
  input  wire logic                    rst_n,        // Async reset, active low.
  input  wire logic [cmd_w-1:0]        cmd,          // Command word.
  input  wire logic                    cmd_rdy,      // Command waiting.
  input  wire logic                    cal_done,     // Gyro calibration done.
  input  wire logic signed [hdg_w-1:0] heading,      // Gyro heading.
  input  wire logic                    heading_rdy,  // New heading this cycle.
  input  wire logic                    lft_ir,       // Left IR sensor.
  input  wire logic                    cntr_ir,      // Centre IR sensor.
  input  wire logic                    rght_ir,      // Right IR sensor.
  output logic                         clr_cmd_rdy,  // Command consumed.
  output logic                         send_resp,    // Command complete.
  output logic                         strt_cal,     // Start gyro calibration.
  output logic                         moving,       // Robot is driving.
  output logic signed [hdg_w-1:0]      error,        // Error to the PID.
  output logic [spd_w-1:0]             frwrd,        // Forward speed.
  output logic                         tour_go,      // Start the tour.
  output logic                         fanfare_go    // Play the fanfare.
);

  logic [3:0]              cmd_op;           // Opcode field of cmd.
  logic [sq_w-1:0]         squares;          // Latched square count.
  logic signed [hdg_w-1:0] desired_heading;  // Latched target heading.
  logic                    aligned;          // Heading close enough.
  logic                    move_done;        // Crossings complete.
  logic                    at_zero;          // Speed is zero.
  logic                    launch;           // Forward run starts.
  logic                    ramp_up_en;       // Accelerate.
  logic                    ramp_down_en;     // Brake.

  assign cmd_op = cmd[cmd_w-1:cmd_w-4];

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////
  cmd_reg cmd_reg_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd             (cmd),
    .accept          (clr_cmd_rdy),
    .squares         (squares),
    .desired_heading (desired_heading)
  );

  heading_err #(.nudge(nudge)) heading_err_i (
    .heading         (heading),
    .desired_heading (desired_heading),
    .lft_ir          (lft_ir),
    .rght_ir         (rght_ir),
    .error           (error),
    .aligned         (aligned)
  );

  square_counter square_counter_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cntr_ir   (cntr_ir),
    .launch    (launch),
    .squares   (squares),
    .move_done (move_done)
  );

  speed_ramp #(.ramp_up(ramp_up), .ramp_down(ramp_down)) speed_ramp_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .launch       (launch),
    .ramp_up_en   (ramp_up_en),
    .ramp_down_en (ramp_down_en),
    .heading_rdy  (heading_rdy),
    .frwrd        (frwrd),
    .at_zero      (at_zero)
  );

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////
  cmd_fsm cmd_fsm_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_rdy      (cmd_rdy),
    .cmd_op       (cmd_op),
    .cal_done     (cal_done),
    .aligned      (aligned),
    .move_done    (move_done),
    .at_zero      (at_zero),
    .clr_cmd_rdy  (clr_cmd_rdy),
    .strt_cal     (strt_cal),
    .send_resp    (send_resp),
    .tour_go      (tour_go),
    .fanfare_go   (fanfare_go),
    .moving       (moving),
    .launch       (launch),
    .ramp_up_en   (ramp_up_en),
    .ramp_down_en (ramp_down_en)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset generator.
// Free-running clock, reset held low for a fixed number of cycles.
`default_nettype none

module tb_clk_gen #(
  parameter int period     = 20,  // Clock period in ns.
  parameter int rst_cycles = 16   // Cycles of reset.
) (
  output logic clk,    // Testbench clock.
  output logic rst_n   // Active low reset.
);
  timeunit 1ns;
  timeprecision 100ps;

  always #(period / 2) clk = ~clk;  // Half period per toggle.

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;                     // Hold the DUT in reset.
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;                     // Release away from the active edge.
  end

endmodule

`default_nettype wire

// ==== dv/cmd_proc_props.sv ====
// Sequencer assertions.
// Strobe relations of the command sequencer, bound into cmd_fsm.
`default_nettype none

module cmd_proc_props
  import knight_pkg::*;
(
  input wire logic       clk,          // System clock.
  input wire logic       rst_n,        // Async reset, active low.
  input wire logic [2:0] state,        // Sequencer state.
  input wire logic       strt_cal,     // Calibration start.
  input wire logic       clr_cmd_rdy,  // Command consumed.
  input wire logic       send_resp,    // Command complete.
  input wire logic       tour_go,      // Tour start.
  input wire logic       fanfare_go,   // Fanfare start.
  input wire logic       moving,       // Robot driving.
  input wire logic       launch        // Forward run start.
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // Failed assertions so far.

  cal_on_accept: assert property (@(posedge clk) disable iff (!rst_n)
    strt_cal |-> clr_cmd_rdy)
    else begin
      $error("strt_cal pulsed without clr_cmd_rdy");
      fail_cnt++;
    end

  resp_not_tour: assert property (@(posedge clk) disable iff (!rst_n)
    !(send_resp && tour_go))
    else begin
      $error("send_resp and tour_go high together");
      fail_cnt++;
    end

  fanfare_moving: assert property (@(posedge clk) disable iff (!rst_n)
    fanfare_go |-> moving)
    else begin
      $error("fanfare_go while not moving");
      fail_cnt++;
    end

  launch_in_move: assert property (@(posedge clk) disable iff (!rst_n)
    launch |-> (state == st_move))
    else begin
      $error("launch outside the turn state");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== dv/cmd_proc_tb.sv ====
// Knight command processor testbench.
// Random commands and sensor activity from an xorshift generator,
// every output compared each cycle against a cycle model.
`default_nettype none

module cmd_proc_tb
  import knight_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_cmds      = 40;                    // Commands to run.
  localparam int cyc_per_cmd = 3000;                  // Worst case per command.
  localparam int cyc_limit   = n_cmds * cyc_per_cmd;  // Timeout.

  logic clk, rst_n;
  logic [cmd_w-1:0] cmd;
  logic cmd_rdy, cal_done, heading_rdy, lft_ir, cntr_ir, rght_ir;
  logic signed [hdg_w-1:0] heading;
  logic clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go;
  logic signed [hdg_w-1:0] error;
  logic [spd_w-1:0] frwrd;

  // Model state.
  logic [2:0]              m_state;   // Sequencer state.
  logic signed [hdg_w-1:0] m_des;     // Desired heading.
  logic [sq_w-1:0]         m_sq;      // Squares of the move.
  logic [sq_w:0]           m_cnt;     // Line crossings.
  logic                    m_ir_q;    // Last centre IR value.
  logic [spd_w-1:0]        m_frwrd;   // Forward speed.
  logic                    m_fan;     // Fanfare move.

  // Expected values for the current cycle.
  logic signed [hdg_w-1:0] exp_err;
  logic exp_aligned, exp_clr, exp_tour, exp_cal, exp_done;
  logic exp_launch, exp_resp, exp_moving, exp_fan;

  logic [31:0] seed = 32'd9912;  // Xorshift state.
  logic        pending;          // Command presented, not yet consumed.
  int err_errs, spd_errs, bit_errs, accepted, cycles, total;

  tb_clk_gen #(.period(20), .rst_cycles(16)) clk_gen_i (.clk(clk), .rst_n(rst_n));

  cmd_proc dut_i (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_rdy(cmd_rdy), .cal_done(cal_done),
    .heading(heading), .heading_rdy(heading_rdy), .lft_ir(lft_ir), .cntr_ir(cntr_ir),
    .rght_ir(rght_ir), .clr_cmd_rdy(clr_cmd_rdy), .send_resp(send_resp),
    .strt_cal(strt_cal), .moving(moving), .error(error), .frwrd(frwrd),
    .tour_go(tour_go), .fanfare_go(fanfare_go)
  );

  bind cmd_fsm cmd_proc_props props_i (
    .clk(clk), .rst_n(rst_n), .state(state), .strt_cal(strt_cal),
    .clr_cmd_rdy(clr_cmd_rdy), .send_resp(send_resp), .tour_go(tour_go),
    .fanfare_go(fanfare_go), .moving(moving), .launch(launch)
  );

  ////////////////////////////////////////
  // Random numbers and compare tasks
  ////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  task automatic check_err(input logic signed [hdg_w-1:0] got,
                           input logic signed [hdg_w-1:0] exp);
    if (got !== exp) begin
      err_errs++;
      $display("ERR %0t: error word %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_spd(input logic [spd_w-1:0] got, input logic [spd_w-1:0] exp);
    if (got !== exp) begin
      spd_errs++;
      $display("ERR %0t: frwrd %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      bit_errs++;
      $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus, prediction, model update
  ////////////////////////////////////////
  task automatic drive_inputs();
    logic [31:0] r;
    logic [3:0]  op;
    r = next_rand();
    if (!pending && accepted < n_cmds && r[2:0] == 3'd0) begin
      pending = 1'b1;                          // New command from the sender.
      r = next_rand();
      case (r[18:16])
        3'd0, 3'd1: op = op_mov;
        3'd2: op = op_fanfare;
        3'd3: op = op_cal;
        3'd4: op = op_tour;
        default: op = r[23:20];                // Any opcode, mostly unused ones.
      endcase
      cmd = {op, r[11:0]};
    end
    cmd_rdy = pending;                         // Held until consumed.
    r = next_rand();
    cal_done    = (r[4:0] == 5'd0);
    heading_rdy = (r[6:5] == 2'd0);
    lft_ir      = (r[9:7] == 3'd0);
    rght_ir     = (r[12:10] == 3'd0);
    if (r[15:13] == 3'd0) begin
      cntr_ir = ~cntr_ir;                      // Line edges at random.
    end
    if (r[16]) begin
      heading = m_des + hdg_w'($signed(r[23:17]));  // Near target, helps alignment.
    end else begin
      heading = r[31:20];
    end
  endtask

  task automatic predict();
    int d;                                     // Unwrapped error.
    int e;                                     // Wrapped error as a number.
    d = int'(heading) - int'(m_des);
    if (lft_ir) begin
      d = d + int'(nudge_default);             // Left sensor has priority.
    end else if (rght_ir) begin
      d = d - int'(nudge_default);
    end
    exp_err     = d[hdg_w-1:0];                // Modulo 12 bits.
    e           = int'(exp_err);
    exp_aligned = (e > -int'(align_tol)) && (e < int'(align_tol));
    exp_clr     = (m_state == st_idle) && cmd_rdy;
    exp_tour    = exp_clr && (cmd[cmd_w-1 -: 4] == op_tour);
    exp_cal     = exp_clr && (cmd[cmd_w-1 -: 4] == op_cal);
    exp_done    = (m_cnt == {m_sq, 1'b0});   // Two lines per square.
    exp_launch  = (m_state == st_move) && exp_aligned;
    exp_resp    = ((m_state == st_cal) && cal_done) || ((m_state == st_decr) && m_frwrd == '0);
    exp_moving  = exp_launch || (m_state == st_incr) || ((m_state == st_decr) && m_frwrd != '0);
    exp_fan     = (m_state == st_incr) && exp_done && m_fan;
  endtask

  task automatic advance_model();
    logic [7:0] fld;
    fld = cmd[hdg_field_msb:hdg_field_lsb];
    if (exp_launch) begin
      m_cnt = '0;
    end else if (cntr_ir && !m_ir_q) begin
      m_cnt = m_cnt + (sq_w + 1)'(1);          // Rising edge of centre IR.
    end
    m_ir_q = cntr_ir;
    if (exp_launch) begin
      m_frwrd = '0;
    end else if (heading_rdy && m_state == st_incr &&
                 !(m_frwrd[spd_w-1] && m_frwrd[spd_w-2])) begin
      m_frwrd = m_frwrd + ramp_up_default;
    end else if (heading_rdy && m_state == st_decr) begin
      m_frwrd = (m_frwrd > ramp_down_default) ? m_frwrd - ramp_down_default : '0;
    end
    if (exp_clr) begin
      m_sq  = cmd[sq_field_msb:0];
      m_des = (fld == 8'd0) ? '0 : {fld, 4'hF};
      m_fan = (cmd[cmd_w-1 -: 4] == op_fanfare);
    end
    case (m_state)
      st_idle: begin
        if (exp_cal) m_state = st_cal;
        else if (exp_clr && (cmd[cmd_w-1 -: 4] inside {op_mov, op_fanfare})) m_state = st_move;
      end
      st_cal:  if (cal_done) m_state = st_idle;
      st_move: if (exp_aligned) m_state = st_incr;
      st_incr: if (exp_done) m_state = st_decr;
      st_decr: if (exp_resp) m_state = st_idle;  // Stopped at the start of this cycle.
      default: m_state = st_idle;
    endcase
  endtask

  initial begin
    cmd         = '0;
    cmd_rdy     = 1'b0;
    cal_done    = 1'b0;
    heading     = '0;
    heading_rdy = 1'b0;
    lft_ir      = 1'b0;
    cntr_ir     = 1'b0;
    rght_ir     = 1'b0;
    m_state     = st_idle;
    m_des       = '0;
    m_sq        = '0;
    m_cnt       = '0;
    m_ir_q      = 1'b0;
    m_frwrd     = '0;
    m_fan       = 1'b0;
    pending     = 1'b0;
    err_errs    = 0;
    spd_errs    = 0;
    bit_errs    = 0;
    accepted    = 0;
    cycles      = 0;
    @(posedge rst_n);
    while (cycles < cyc_limit && !(accepted == n_cmds && m_state == st_idle)) begin
      @(negedge clk);
      drive_inputs();
      #5;                                      // Mid low phase, outputs settled.
      predict();
      check_err(error, exp_err);
      check_spd(frwrd, m_frwrd);
      check_bit(clr_cmd_rdy, exp_clr, "clr_cmd_rdy");
      check_bit(strt_cal, exp_cal, "strt_cal");
      check_bit(tour_go, exp_tour, "tour_go");
      check_bit(send_resp, exp_resp, "send_resp");
      check_bit(moving, exp_moving, "moving");
      check_bit(fanfare_go, exp_fan, "fanfare_go");
      if (exp_clr) begin
        pending = 1'b0;
        accepted++;
      end
      advance_model();
      cycles++;
    end
    total = err_errs + spd_errs + bit_errs + int'(dut_i.cmd_fsm_i.props_i.fail_cnt);
    $display("Errors: error word %0d, speed %0d, strobes %0d, assertions %0d",
             err_errs, spd_errs, bit_errs, dut_i.cmd_fsm_i.props_i.fail_cnt);
    if (cycles >= cyc_limit) begin
      $display("Timeout: only %0d of %0d commands done in %0d cycles", accepted, n_cmds, cycles);
    end
    if (cycles < cyc_limit && total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
source/knight_pkg.sv
source/cmd_reg.sv
source/heading_err.sv
source/square_counter.sv
source/speed_ramp.sv
source/cmd_fsm.sv
source/cmd_proc.sv
dv/tb_clk_gen.sv
dv/cmd_proc_props.sv
dv/cmd_proc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the command processor testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cmd_proc_tb -f all.f \
  -o sim_cmd_proc > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_cmd_proc +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "^TESTS PASSED$" sim.log && exit 0 || exit 1
